/* include/eeprom_i2c_config.svh */
`ifndef EEPROM_I2C_CONFIG_SVH
`define EEPROM_I2C_CONFIG_SVH

// clk cycles per quarter scl period
`define EEPROM_I2C_QDIV 4

// 2 KB part, 11-bit byte address
`define EEPROM_I2C_ADDR_W 11

`define EEPROM_I2C_DEV_CODE 4'b1010

// apb byte offsets
`define EEPROM_I2C_REG_ADDR   8'h00
`define EEPROM_I2C_REG_WDATA  8'h04
`define EEPROM_I2C_REG_CMD    8'h08
`define EEPROM_I2C_REG_RDATA  8'h0C
`define EEPROM_I2C_REG_STATUS 8'h10

`endif

/* src/eeprom_i2c_pkg.sv */
`default_nettype none

`include "eeprom_i2c_config.svh"

package eeprom_i2c_pkg;

    // one bus operation for the bit engine
    typedef enum logic [1:0]
    {
        COND_START = 2'd0,
        COND_STOP  = 2'd1,
        COND_WRITE = 2'd2,
        COND_READ  = 2'd3
    } i2c_cond_t;

    // software command as written to CMD
    typedef enum logic [1:0]
    {
        CMD_NONE  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_READ  = 2'd2
    } eeprom_cmd_t;

    // upper 3 bits select the 256-byte block
    typedef logic [`EEPROM_I2C_ADDR_W-1:0] eeprom_addr_t;

    typedef logic [7:0] eeprom_byte_t; // data or control byte

endpackage

`default_nettype wire

/* src/i2c_bit_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_i2c_config.svh"

module i2c_bit_engine
(
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         op_valid,
    output logic                         op_ready,
    input  eeprom_i2c_pkg::i2c_cond_t    op,
    input  eeprom_i2c_pkg::eeprom_byte_t op_byte,
    input  logic                         op_mack,
    output logic                         res_valid,
    output eeprom_i2c_pkg::eeprom_byte_t res_byte,
    output logic                         res_nack,
    output logic                         scl,
    output logic                         sda_oe,
    input  logic                         sda_in
);
    import eeprom_i2c_pkg::*;

    localparam int QDIV = `EEPROM_I2C_QDIV;
    localparam int QW = (QDIV > 1) ? $clog2(QDIV) : 1;

    typedef enum logic [1:0] {E_IDLE, E_START, E_STOP, E_BYTE} eng_state_t;

    eng_state_t    state;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;   // quarter within the current bit
    logic [3:0]    bit_cnt; // 8 is the ack slot
    eeprom_byte_t  shreg;
    logic          rd_mode;
    logic          mack;
    logic          ack_bit;
    logic          tick;

    assign op_ready = (state == E_IDLE);
    assign tick     = (qcnt == QW'(QDIV - 1));

    // phase 0 scl low, 1-2 scl high, 3 scl low again
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= E_IDLE;
            qcnt      <= '0;
            phase     <= '0;
            bit_cnt   <= '0;
            rd_mode   <= 1'b0;
            mack      <= 1'b0;
            ack_bit   <= 1'b0;
            res_valid <= 1'b0;
            res_nack  <= 1'b0;
            scl       <= 1'b1;
            sda_oe    <= 1'b0;
        end
        else
        begin
            res_valid <= 1'b0;
            if (state == E_IDLE)
            begin
                qcnt    <= '0;
                phase   <= '0;
                bit_cnt <= '0;
                if (op_valid)
                begin
                    shreg   <= op_byte;
                    rd_mode <= (op == COND_READ);
                    mack    <= op_mack;
                    case (op)
                        COND_START:
                        begin
                            state  <= E_START;
                            sda_oe <= 1'b0; // release first, scl may still be low
                        end
                        COND_STOP:
                        begin
                            state  <= E_STOP;
                            scl    <= 1'b0;
                            sda_oe <= 1'b1;
                        end
                        default:
                        begin
                            state  <= E_BYTE;
                            scl    <= 1'b0;
                            sda_oe <= (op == COND_WRITE) & ~op_byte[7];
                        end
                    endcase
                end
            end
            else if (!tick)
            begin
                qcnt <= qcnt + 1'b1;
            end
            else
            begin
                qcnt  <= '0;
                phase <= phase + 1'b1;
                case (phase)
                    2'd0: scl <= 1'b1;
                    2'd1:
                    begin
                        if (state == E_START)
                            sda_oe <= 1'b1;  // sda falls with scl high
                        else if (state == E_STOP)
                            sda_oe <= 1'b0;  // sda rises with scl high
                        else if (bit_cnt == 4'd8)
                            ack_bit <= sda_in;
                        else
                            shreg <= {shreg[6:0], sda_in};
                    end
                    2'd2:
                    begin
                        if (state != E_STOP)
                            scl <= 1'b0;
                    end
                    default:
                    begin
                        if (state != E_BYTE || bit_cnt == 4'd8)
                        begin
                            state     <= E_IDLE;
                            res_valid <= 1'b1;
                            res_nack  <= (state == E_BYTE) & ack_bit;
                            if (state == E_BYTE)
                                res_byte <= shreg;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 4'd7)
                                sda_oe <= rd_mode ? ~mack : 1'b0;
                            else
                                sda_oe <= ~rd_mode & ~shreg[7];
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/eeprom_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_i2c_config.svh"

module eeprom_seq
(
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         cmd_start,
    input  eeprom_i2c_pkg::eeprom_cmd_t  cmd,
    input  eeprom_i2c_pkg::eeprom_addr_t addr,
    input  eeprom_i2c_pkg::eeprom_byte_t wdata,
    output logic                         busy,
    output logic                         rdata_valid,
    output eeprom_i2c_pkg::eeprom_byte_t rdata,
    output logic                         fin,
    output logic                         nack,
    output logic                         op_valid,
    input  logic                         op_ready,
    output eeprom_i2c_pkg::i2c_cond_t    op,
    output eeprom_i2c_pkg::eeprom_byte_t op_byte,
    output logic                         op_mack,
    input  logic                         res_valid,
    input  eeprom_i2c_pkg::eeprom_byte_t res_byte,
    input  logic                         res_nack
);
    import eeprom_i2c_pkg::*;

    typedef enum logic [3:0]
    {
        S_IDLE, S_START, S_CTRL, S_ADDR, S_DATA,
        S_RESTART, S_CTRLRD, S_READ, S_STOP
    } seq_state_t;

    seq_state_t   state;
    logic         is_read;
    logic         nack_r;
    eeprom_addr_t addr_r;
    eeprom_byte_t wdata_r;
    eeprom_byte_t ctrl_wr;
    eeprom_byte_t ctrl_rd;

    // 1010, block bits, r/w
    assign ctrl_wr = {`EEPROM_I2C_DEV_CODE, addr_r[`EEPROM_I2C_ADDR_W-1:8], 1'b0};
    assign ctrl_rd = {`EEPROM_I2C_DEV_CODE, addr_r[`EEPROM_I2C_ADDR_W-1:8], 1'b1};

    assign busy    = (state != S_IDLE);
    assign fin     = (state == S_STOP) & res_valid; // done and busy move together
    assign nack    = nack_r;
    assign op_mack = (state == S_READ); // single-byte read ends with nack

    always_comb
    begin
        op      = COND_WRITE;
        op_byte = ctrl_wr;
        case (state)
            S_START, S_RESTART: op = COND_START;
            S_ADDR:   op_byte = addr_r[7:0];
            S_DATA:   op_byte = wdata_r;
            S_CTRLRD: op_byte = ctrl_rd;
            S_READ:   op = COND_READ;
            S_STOP:   op = COND_STOP;
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= S_IDLE;
            op_valid    <= 1'b0;
            is_read     <= 1'b0;
            nack_r      <= 1'b0;
            rdata_valid <= 1'b0;
        end
        else
        begin
            rdata_valid <= 1'b0;
            if (state == S_IDLE)
            begin
                if (cmd_start)
                begin
                    addr_r   <= addr;
                    wdata_r  <= wdata;
                    is_read  <= (cmd == CMD_READ);
                    nack_r   <= 1'b0;
                    state    <= S_START;
                    op_valid <= 1'b1;
                end
            end
            else
            begin
                if (op_valid && op_ready)
                    op_valid <= 1'b0;
                if (res_valid)
                begin
                    op_valid <= 1'b1; // next op right after the result
                    case (state)
                        S_START:   state <= S_CTRL;
                        S_RESTART: state <= S_CTRLRD;
                        S_READ:
                        begin
                            rdata       <= res_byte;
                            rdata_valid <= 1'b1;
                            state       <= S_STOP;
                        end
                        S_STOP:
                        begin
                            op_valid <= 1'b0;
                            state    <= S_IDLE;
                        end
                        default:
                        begin
                            // written byte, abort on nack
                            if (res_nack)
                            begin
                                nack_r <= 1'b1;
                                state  <= S_STOP;
                            end
                            else if (state == S_CTRL)
                                state <= S_ADDR;
                            else if (state == S_ADDR)
                                state <= is_read ? S_RESTART : S_DATA;
                            else if (state == S_CTRLRD)
                                state <= S_READ;
                            else
                                state <= S_STOP;
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/apb_eeprom_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_i2c_config.svh"

module apb_eeprom_regs
(
    input  logic                         CLK,
    input  logic                         RESET,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [7:0]                   paddr,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         cmd_start,
    output eeprom_i2c_pkg::eeprom_cmd_t  cmd,
    output eeprom_i2c_pkg::eeprom_addr_t addr,
    output eeprom_i2c_pkg::eeprom_byte_t wdata,
    input  logic                         busy,
    input  logic                         rdata_valid,
    input  eeprom_i2c_pkg::eeprom_byte_t rdata,
    input  logic                         fin,
    input  logic                         nack
);
    import eeprom_i2c_pkg::*;

    logic         access;
    logic         wr_access;
    logic         mapped;
    logic         cmd_hit;
    logic         done;
    logic         nack_err;
    eeprom_byte_t rdata_r;

    assign access    = psel & penable;
    assign wr_access = access & pwrite;
    assign cmd_hit   = wr_access & (paddr == `EEPROM_I2C_REG_CMD);
    assign pready    = 1'b1; // never stalls

    assign cmd_start = cmd_hit & ~busy & ((pwdata == 32'd1) | (pwdata == 32'd2));
    assign cmd       = eeprom_cmd_t'(pwdata[1:0]);
    assign pslverr   = access & (~mapped | (cmd_hit & busy));

    always_comb
    begin
        mapped = 1'b1;
        case (paddr)
            `EEPROM_I2C_REG_ADDR:   prdata = {21'd0, addr};
            `EEPROM_I2C_REG_WDATA:  prdata = {24'd0, wdata};
            `EEPROM_I2C_REG_CMD:    prdata = 32'd0;
            `EEPROM_I2C_REG_RDATA:  prdata = {24'd0, rdata_r};
            `EEPROM_I2C_REG_STATUS: prdata = {29'd0, done, nack_err, busy};
            default:
            begin
                mapped = 1'b0;
                prdata = 32'd0;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            addr     <= '0;
            wdata    <= '0;
            rdata_r  <= '0;
            done     <= 1'b0;
            nack_err <= 1'b0;
        end
        else
        begin
            if (wr_access && paddr == `EEPROM_I2C_REG_ADDR)
                addr <= pwdata[`EEPROM_I2C_ADDR_W-1:0];
            if (wr_access && paddr == `EEPROM_I2C_REG_WDATA)
                wdata <= pwdata[7:0];
            if (rdata_valid)
                rdata_r <= rdata;
            if (cmd_start)
            begin
                done     <= 1'b0;
                nack_err <= 1'b0;
            end
            else if (fin)
            begin
                done     <= 1'b1; // sticky
                nack_err <= nack;
            end
        end
    end

endmodule

`default_nettype wire

/* src/eeprom_i2c_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_i2c_top
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        scl,
    output logic        sda_oe,
    input  logic        sda_in
);
    import eeprom_i2c_pkg::*;

    logic         cmd_start;
    eeprom_cmd_t  cmd;
    eeprom_addr_t addr;
    eeprom_byte_t wdata;
    logic         busy;
    logic         rdata_valid;
    eeprom_byte_t rdata;
    logic         fin;
    logic         nack;

    // sequencer to bit engine
    logic         op_valid;
    logic         op_ready;
    i2c_cond_t    op;
    eeprom_byte_t op_byte;
    logic         op_mack;
    logic         res_valid;
    eeprom_byte_t res_byte;
    logic         res_nack;

    apb_eeprom_regs u_regs
    (
        .CLK(CLK), .RESET(RESET),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cmd_start(cmd_start), .cmd(cmd), .addr(addr), .wdata(wdata),
        .busy(busy), .rdata_valid(rdata_valid), .rdata(rdata), .fin(fin), .nack(nack)
    );

    eeprom_seq u_seq
    (
        .CLK(CLK), .RESET(RESET),
        .cmd_start(cmd_start), .cmd(cmd), .addr(addr), .wdata(wdata),
        .busy(busy), .rdata_valid(rdata_valid), .rdata(rdata), .fin(fin), .nack(nack),
        .op_valid(op_valid), .op_ready(op_ready), .op(op), .op_byte(op_byte),
        .op_mack(op_mack), .res_valid(res_valid), .res_byte(res_byte),
        .res_nack(res_nack)
    );

    i2c_bit_engine u_engine
    (
        .CLK(CLK), .RESET(RESET),
        .op_valid(op_valid), .op_ready(op_ready), .op(op), .op_byte(op_byte),
        .op_mack(op_mack), .res_valid(res_valid), .res_byte(res_byte),
        .res_nack(res_nack), .scl(scl), .sda_oe(sda_oe), .sda_in(sda_in)
    );

endmodule

`default_nettype wire

/* tb/eeprom_model.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_model
(
    input  logic scl,
    input  logic sda,
    input  logic nack_inject,
    output logic sda_pull,
    output int   proto_errors
);
    logic [7:0]  mem [0:2047];
    logic [7:0]  sh;
    logic [7:0]  txbyte;
    logic [7:0]  wbyte;
    logic [10:0] ptr;
    int          bitn;
    int          byte_idx;
    logic        active;
    logic        tx_mode;
    logic        tx_next;
    logic        ack_phase;
    logic        wr_pending;
    logic        ack;

    initial
    begin
        sda_pull     = 1'b0;
        proto_errors = 0;
        active       = 1'b0;
        wr_pending   = 1'b0;
        ptr          = '0;
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i ^ (i >> 3)); // fill from the whole address
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active    = 1'b1;
            byte_idx  = 0;
            bitn      = 0;
            tx_mode   = 1'b0;
            tx_next   = 1'b0;
            ack_phase = 1'b0;
        end
    end

    // stop commits a pending write
    always @(posedge sda)
    begin
        if (scl === 1'b1 && active)
        begin
            active = 1'b0;
            if (wr_pending)
                mem[ptr] = wbyte;
            wr_pending = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (active && !ack_phase)
        begin
            if (!tx_mode)
                sh = {sh[6:0], sda};
            bitn++;
        end
    end

    always @(negedge scl)
    begin
        if (active)
        begin
            if (ack_phase)
            begin
                ack_phase = 1'b0;
                bitn      = 0;
                if (tx_next)
                begin
                    tx_mode  = 1'b1;
                    tx_next  = 1'b0;
                    sda_pull <= ~txbyte[7];
                end
                else
                    sda_pull <= 1'b0;
            end
            else if (bitn == 8)
            begin
                ack_phase = 1'b1;
                if (tx_mode)
                    sda_pull <= 1'b0; // master ack slot
                else
                begin
                    ack = !nack_inject;
                    case (byte_idx)
                        0:
                        begin
                            if (sh[7:4] != 4'b1010)
                            begin
                                proto_errors++;
                                ack = 1'b0;
                            end
                            if (sh[0])
                            begin
                                if (sh[3:1] != ptr[10:8])
                                    proto_errors++; // block bits must repeat
                                txbyte  = mem[ptr];
                                tx_next = ack;
                            end
                            else
                                ptr[10:8] = sh[3:1];
                        end
                        1: ptr[7:0] = sh;
                        default:
                        begin
                            wbyte      = sh;
                            wr_pending = ack;
                        end
                    endcase
                    byte_idx++;
                    sda_pull <= ack;
                end
            end
            else if (tx_mode && bitn > 0)
                sda_pull <= ~txbyte[7-bitn];
        end
    end

endmodule

`default_nettype wire

/* tb/eeprom_i2c_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_i2c_properties
(
    input logic                      CLK,
    input logic                      RESET,
    input logic                      scl,
    input logic                      sda_in,
    input logic                      busy,
    input logic                      psel,
    input logic                      penable,
    input logic                      pslverr,
    input logic                      op_valid,
    input logic                      op_ready,
    input eeprom_i2c_pkg::i2c_cond_t op
);
    int fail_count = 0;

    // start and stop only inside a transfer
    a_sda_idle: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_in != $past(sda_in)) |-> busy)
        else
        begin
            $error("sda moved with scl high while idle");
            fail_count++;
        end

    a_slverr: assert property (@(posedge CLK) disable iff (RESET)
        pslverr |-> (psel && penable))
        else
        begin
            $error("pslverr outside access phase");
            fail_count++;
        end

    a_op_hold: assert property (@(posedge CLK) disable iff (RESET)
        (op_valid && !op_ready) |=> (op_valid && op == $past(op)))
        else
        begin
            $error("op dropped or changed before op_ready");
            fail_count++;
        end

endmodule

bind eeprom_i2c_top eeprom_i2c_properties u_props
(
    .CLK(CLK), .RESET(RESET), .scl(scl), .sda_in(sda_in), .busy(busy),
    .psel(psel), .penable(penable), .pslverr(pslverr),
    .op_valid(op_valid), .op_ready(op_ready), .op(op)
);

`default_nettype wire

/* tb/eeprom_i2c_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_i2c_config.svh"

module eeprom_i2c_tb;
    import eeprom_i2c_pkg::*;

    localparam int N_TRANS = 30;
    localparam longint LIMIT_NS = N_TRANS * 40 * 16 * 8 + 20000;

    logic         CLK;
    logic         RESET;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [7:0]   paddr;
    logic [31:0]  pwdata;
    logic [31:0]  prdata;
    logic         pready;
    logic         pslverr;
    logic         scl;
    logic         sda_oe;
    logic         sda_pull;
    logic         sda;
    logic         nack_inject;
    int           errors;
    int           proto_errors;
    eeprom_byte_t shadow [0:2047];
    eeprom_byte_t exp_q [$];
    eeprom_byte_t act_q [$];
    eeprom_addr_t addrs [8];
    eeprom_byte_t datas [8];
    int           order [8];

    assign sda = ~(sda_oe | sda_pull); // wired-and

    eeprom_i2c_top u_eeprom_i2c_top
    (
        .CLK(CLK), .RESET(RESET), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .scl(scl), .sda_oe(sda_oe), .sda_in(sda)
    );

    eeprom_model u_eeprom
    (
        .scl(scl), .sda(sda), .nack_inject(nack_inject),
        .sda_pull(sda_pull), .proto_errors(proto_errors)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial
    begin
        #(LIMIT_NS);
        $display("timeout: transfers did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    function automatic eeprom_byte_t expected_byte(input eeprom_addr_t a);
        return shadow[a];
    endfunction

    task automatic check_byte(input string name, input eeprom_byte_t exp,
                              input eeprom_byte_t act);
        if (act !== exp)
        begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_status(input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp)
        begin
            errors++;
            $display("ERROR status expected %h actual %h", exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // compares read data as it arrives
    initial
    begin
        forever
        begin
            @(posedge CLK);
            while (act_q.size() > 0)
                check_byte("rdata", exp_q.pop_front(), act_q.pop_front());
        end
    end

    task automatic apb_access(input logic wr, input logic [7:0] a, input logic [31:0] d,
                              output logic [31:0] rd, output logic err);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(negedge CLK);
        penable = 1'b1;
        #1;
        rd  = prdata;
        err = pslverr;
        check_flag("pready", 1'b1, pready);
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // polls STATUS until done with busy low
    task automatic apb_read(output logic [2:0] st);
        logic [31:0] rd;
        logic        err;
        int          n;
        n  = 0;
        st = '0;
        while (n < 2000)
        begin
            apb_access(1'b0, `EEPROM_I2C_REG_STATUS, 32'd0, rd, err);
            st = rd[2:0];
            if (st[2] && !st[0])
                return;
            n++;
        end
        errors++;
        $display("command never reported done");
    endtask

    task automatic run_cmd(input eeprom_cmd_t c, input eeprom_addr_t a, input eeprom_byte_t d,
                           output logic [2:0] st);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, `EEPROM_I2C_REG_ADDR, 32'(a), rd, err);
        apb_access(1'b1, `EEPROM_I2C_REG_WDATA, 32'(d), rd, err);
        apb_access(1'b1, `EEPROM_I2C_REG_CMD, 32'(c), rd, err);
        check_flag("pslverr", 1'b0, err);
        apb_read(st);
    endtask

    task automatic write_byte(input eeprom_addr_t a, input eeprom_byte_t d);
        logic [2:0] st;
        run_cmd(CMD_WRITE, a, d, st);
        check_status({1'b1, nack_inject, 1'b0}, st);
        if (!nack_inject)
            shadow[a] = d; // only acknowledged writes land
    endtask

    task automatic read_byte(input eeprom_addr_t a);
        logic [2:0]  st;
        logic [31:0] rd;
        logic        err;
        run_cmd(CMD_READ, a, 8'h00, st);
        check_status(3'b100, st);
        apb_access(1'b0, `EEPROM_I2C_REG_RDATA, 32'd0, rd, err);
        exp_q.push_back(expected_byte(a));
        act_q.push_back(rd[7:0]);
    endtask

    initial
    begin
        logic [31:0]  rd;
        logic         err;
        logic [2:0]   st;
        int           j;
        int           tmp;
        eeprom_addr_t a;
        eeprom_byte_t lo;
        eeprom_byte_t d;
        void'($urandom(32'hddbefbce));
        errors      = 0;
        RESET       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        nack_inject = 1'b0;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'(i ^ (i >> 3));
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        check_flag("scl", 1'b1, scl);
        check_flag("sda_oe", 1'b0, sda_oe);
        apb_access(1'b0, `EEPROM_I2C_REG_STATUS, 32'd0, rd, err);
        check_status(3'b000, rd[2:0]);
        apb_access(1'b0, `EEPROM_I2C_REG_RDATA, 32'd0, rd, err);
        check_byte("rdata", 8'h00, rd[7:0]);

        // same low byte in every block, so only the block bits tell them apart
        lo = 8'($urandom);
        for (int i = 0; i < 8; i++)
        begin
            addrs[i] = {3'(i), lo};
            datas[i] = 8'($urandom);
            order[i] = i;
            write_byte(addrs[i], datas[i]);
        end
        for (int i = 7; i > 0; i--)
        begin
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 8; i++)
            read_byte(addrs[order[i]]);

        a = 11'($urandom);
        d = 8'($urandom);
        write_byte(a, d);
        write_byte(a, ~d);
        read_byte(a);

        nack_inject = 1'b1;
        write_byte(addrs[0], ~expected_byte(addrs[0]));
        nack_inject = 1'b0;
        read_byte(addrs[0]); // also clears nack_err

        d = ~expected_byte(addrs[5]);
        apb_access(1'b1, `EEPROM_I2C_REG_ADDR, 32'(addrs[5]), rd, err);
        apb_access(1'b1, `EEPROM_I2C_REG_WDATA, 32'(d), rd, err);
        apb_access(1'b1, `EEPROM_I2C_REG_CMD, 32'd1, rd, err);
        apb_access(1'b1, `EEPROM_I2C_REG_CMD, 32'd2, rd, err);
        check_flag("pslverr", 1'b1, err);
        apb_read(st);
        check_status(3'b100, st);
        shadow[addrs[5]] = d;
        read_byte(addrs[5]);

        apb_access(1'b0, 8'h14, 32'd0, rd, err);
        check_flag("pslverr", 1'b1, err);

        while (act_q.size() > 0)
            @(posedge CLK);
        repeat (2) @(posedge CLK);
        if (proto_errors != 0)
        begin
            errors++;
            $display("eeprom model saw a bad control byte");
        end
        if (u_eeprom_i2c_top.u_props.fail_count != 0)
        begin
            errors++;
            $display("bus or apb protocol assertions failed");
        end
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* eeprom_i2c.f */
+incdir+include
src/eeprom_i2c_pkg.sv
src/i2c_bit_engine.sv
src/eeprom_seq.sv
src/apb_eeprom_regs.sv
src/eeprom_i2c_top.sv
tb/eeprom_model.sv
tb/eeprom_i2c_properties.sv
tb/eeprom_i2c_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= eeprom_i2c_tb
RTL_TOP   ?= eeprom_i2c_top
FILELIST  ?= eeprom_i2c.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
